// File: xm_config.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// build constants; timer ratio assumes a 50 kHz clock for sim
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef XM_CONFIG_SVH
`define XM_CONFIG_SVH

// tick rate is HZ_REDUCED ticks per CLK_REDUCED clocks
`define XM_TIMER_CLK_REDUCED 5          // clocks per reduced period
`define XM_TIMER_HZ_REDUCED  1          // ticks per reduced period

`define XM_WRMASK_RESET      4'b1111    // all nibbles written

`endif

// File: xm_types_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// every register and memory word is 16 bits
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package xm_types_pkg;

    typedef logic [7:0]  byte_t;    // host bus byte
    typedef logic [15:0] word_t;    // register / memory data
    typedef logic [15:0] addr_t;    // VRAM and XR address
    typedef logic [6:0]  intr_t;    // one bit per interrupt source
    typedef logic [3:0]  wrmask_t;  // nibble enables, bit 3 = top nibble

endpackage

// File: xm_regmap_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// register numbers 12..15 are unused and read as zero
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package xm_regmap_pkg;

    typedef enum logic [3:0] {
        SYS_CTRL = 4'd0,    // busy flag, write mask
        INT_CTRL = 4'd1,    // irq mask / clear / status
        TIMER    = 4'd2,    // tenth ms counter
        RD_XADDR = 4'd3,    // XR read address, odd write pre-reads
        WR_XADDR = 4'd4,    // XR write address
        XDATA    = 4'd5,    // XR data
        RD_INCR  = 4'd6,    // VRAM read step
        RD_ADDR  = 4'd7,    // VRAM read address, odd write pre-reads
        WR_INCR  = 4'd8,    // VRAM write step
        WR_ADDR  = 4'd9,    // VRAM write address
        DATA     = 4'd10,   // VRAM data
        DATA_2   = 4'd11    // alias of DATA
    } xm_reg_t;

    localparam int SYS_BUSY_BIT = 15;   // in SYS_CTRL readback

endpackage

// File: bus_sync.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// select low >= 6 clk and high >= 3 clk; pins settle before select falls
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module bus_sync (
    input  logic                   clk,
    input  logic                   reset_i,
    input  logic                   bus_cs_n_i,       // async select, active low
    input  logic                   bus_rd_nwr_i,     // 1 = read
    input  xm_regmap_pkg::xm_reg_t bus_reg_num_i,
    input  logic                   bus_bytesel_i,    // 0 = high byte
    input  xm_types_pkg::byte_t    bus_data_i,
    output logic                   wr_strobe_o,      // one clk per write select
    output logic                   rd_strobe_o,      // one clk per read select
    output xm_regmap_pkg::xm_reg_t reg_num_o,        // held until next select
    output logic                   bytesel_o,
    output xm_types_pkg::byte_t    data_byte_o
);
    import xm_types_pkg::*;
    import xm_regmap_pkg::*;

    logic [2:0]     cs_sync;        // two sync stages plus previous value
    logic [1:0]     rd_sync;
    logic [1:0]     bytesel_sync;
    xm_reg_t [1:0]  reg_sync;
    byte_t [1:0]    data_sync;
    logic           cs_fall;

    assign cs_fall = cs_sync[2] && !cs_sync[1];    // synced select just went low

    always_ff @(posedge clk) begin
        rd_sync      <= {rd_sync[0], bus_rd_nwr_i};
        bytesel_sync <= {bytesel_sync[0], bus_bytesel_i};
        reg_sync[0]  <= bus_reg_num_i;
        reg_sync[1]  <= reg_sync[0];
        data_sync[0] <= bus_data_i;
        data_sync[1] <= data_sync[0];
        if (cs_fall) begin
            data_byte_o <= data_sync[1];    // write byte, stable by now
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            cs_sync     <= 3'b111;          // idle = deselected
            wr_strobe_o <= 1'b0;
            rd_strobe_o <= 1'b0;
            reg_num_o   <= SYS_CTRL;
            bytesel_o   <= 1'b0;
        end else begin
            cs_sync     <= {cs_sync[1:0], bus_cs_n_i};
            wr_strobe_o <= cs_fall && !rd_sync[1];
            rd_strobe_o <= cs_fall && rd_sync[1];
            if (cs_fall) begin
                reg_num_o <= reg_sync[1];
                bytesel_o <= bytesel_sync[1];
            end
        end
    end

    // at most one strobe, and never two host accesses in back-to-back cycles
    a_strobe_single : assert property (@(posedge clk) disable iff (reset_i)
        (wr_strobe_o || rd_strobe_o) |-> !(wr_strobe_o && rd_strobe_o)
            ##1 !(wr_strobe_o || rd_strobe_o));

endmodule

// File: tenth_ms_timer.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// count wraps at 16 bits; rate set by the ratio in xm_config.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`include "xm_config.svh"

module tenth_ms_timer (
    input  logic                clk,
    input  logic                reset_i,
    output xm_types_pkg::word_t timer_o    // free-running tick count
);
    import xm_types_pkg::*;

    localparam int FRAC_BITS = $clog2(`XM_TIMER_CLK_REDUCED) + 1;  // room for sign

    logic signed [FRAC_BITS-1:0] frac;     // fractional tick accumulator
    word_t                       count;
    logic                        tick;

    assign tick    = !frac[FRAC_BITS-1];   // accumulator went non-negative
    assign timer_o = count;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            frac  <= '0;
            count <= '0;
        end else if (tick) begin
            // pay back one whole period on every tick
            frac  <= frac + FRAC_BITS'(`XM_TIMER_HZ_REDUCED - `XM_TIMER_CLK_REDUCED);
            count <= count + 16'd1;
        end else begin
            frac  <= frac + FRAC_BITS'(`XM_TIMER_HZ_REDUCED);
        end
    end

endmodule

// File: xm_mem_port.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// host must poll busy; a trigger while busy is ignored
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module xm_mem_port #(
    parameter bit                     HAS_INCR     = 1'b1,   // 0 = step of one
    parameter xm_regmap_pkg::xm_reg_t RD_ADDR_REG  = xm_regmap_pkg::RD_ADDR,
    parameter xm_regmap_pkg::xm_reg_t WR_ADDR_REG  = xm_regmap_pkg::WR_ADDR,
    parameter xm_regmap_pkg::xm_reg_t RD_INCR_REG  = xm_regmap_pkg::RD_INCR,
    parameter xm_regmap_pkg::xm_reg_t WR_INCR_REG  = xm_regmap_pkg::WR_INCR,
    parameter xm_regmap_pkg::xm_reg_t DATA_REG     = xm_regmap_pkg::DATA,
    parameter xm_regmap_pkg::xm_reg_t DATA_ALT_REG = xm_regmap_pkg::DATA_2
) (
    input  logic                   clk,
    input  logic                   reset_i,
    input  logic                   wr_strobe_i,
    input  logic                   rd_strobe_i,
    input  xm_regmap_pkg::xm_reg_t reg_num_i,
    input  logic                   bytesel_i,
    input  xm_types_pkg::byte_t    data_byte_i,
    input  logic                   ack_i,       // only while sel_o high
    input  xm_types_pkg::word_t    mem_data_i,
    output logic                   sel_o,
    output logic                   wr_o,
    output xm_types_pkg::addr_t    addr_o,
    output xm_types_pkg::word_t    data_o,
    output logic                   busy_o,
    output xm_types_pkg::word_t    rd_word_o    // zero outside own registers
);
    import xm_types_pkg::*;
    import xm_regmap_pkg::*;

    typedef enum logic [2:0] {ST_IDLE, ST_READ, ST_WRITE, ST_RINC, ST_WINC} state_t;

    state_t state;
    addr_t  rd_addr;
    addr_t  wr_addr;
    word_t  rd_incr;
    word_t  wr_incr;
    word_t  rd_data;        // last word fetched
    byte_t  data_even;      // high byte of pending write
    word_t  rd_step;
    word_t  wr_step;
    logic   is_data;
    logic   start_rd;
    logic   start_wr;

    assign is_data  = (reg_num_i == DATA_REG) || (reg_num_i == DATA_ALT_REG);
    assign rd_step  = HAS_INCR ? rd_incr : 16'd1;
    assign wr_step  = HAS_INCR ? wr_incr : 16'd1;
    // odd byte write of read addr, or odd byte read of data, fetches ahead
    assign start_rd = (state == ST_IDLE) && bytesel_i &&
                      ((wr_strobe_i && reg_num_i == RD_ADDR_REG) || (rd_strobe_i && is_data));
    assign start_wr = (state == ST_IDLE) && bytesel_i && wr_strobe_i && is_data;

    assign sel_o  = (state == ST_READ) || (state == ST_WRITE);
    assign wr_o   = (state == ST_WRITE);
    assign busy_o = (state != ST_IDLE);     // covers the address step too

    always_ff @(posedge clk) begin
        if (wr_strobe_i && !bytesel_i && is_data) begin
            data_even <= data_byte_i;
        end
        if (start_rd) begin
            addr_o <= wr_strobe_i ? {rd_addr[15:8], data_byte_i} : rd_addr;
        end
        if (start_wr) begin
            addr_o <= wr_addr;
            data_o <= {data_even, data_byte_i};
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state   <= ST_IDLE;
            rd_addr <= '0;
            wr_addr <= '0;
            rd_incr <= '0;
            wr_incr <= '0;
            rd_data <= '0;
        end else begin
            case (state)
                ST_READ: begin
                    if (ack_i) begin
                        rd_data <= mem_data_i;
                        state   <= ST_RINC;
                    end
                end
                ST_WRITE: begin
                    if (ack_i) begin
                        state <= ST_WINC;
                    end
                end
                ST_RINC: begin
                    rd_addr <= rd_addr + rd_step;
                    state   <= ST_IDLE;
                end
                ST_WINC: begin
                    wr_addr <= wr_addr + wr_step;
                    state   <= ST_IDLE;
                end
                default: begin
                    if (start_rd) begin
                        state <= ST_READ;
                    end else if (start_wr) begin
                        state <= ST_WRITE;
                    end
                end
            endcase
            if (wr_strobe_i) begin                  // byte writes, even = high half
                if (reg_num_i == RD_ADDR_REG) begin
                    if (bytesel_i) rd_addr[7:0] <= data_byte_i;
                    else           rd_addr[15:8] <= data_byte_i;
                end else if (reg_num_i == WR_ADDR_REG) begin
                    if (bytesel_i) wr_addr[7:0] <= data_byte_i;
                    else           wr_addr[15:8] <= data_byte_i;
                end else if (HAS_INCR && reg_num_i == RD_INCR_REG) begin
                    if (bytesel_i) rd_incr[7:0] <= data_byte_i;
                    else           rd_incr[15:8] <= data_byte_i;
                end else if (HAS_INCR && reg_num_i == WR_INCR_REG) begin
                    if (bytesel_i) wr_incr[7:0] <= data_byte_i;
                    else           wr_incr[15:8] <= data_byte_i;
                end
            end
        end
    end

    always_comb begin
        rd_word_o = '0;
        if (reg_num_i == RD_ADDR_REG)                  rd_word_o = rd_addr;
        else if (reg_num_i == WR_ADDR_REG)             rd_word_o = wr_addr;
        else if (HAS_INCR && reg_num_i == RD_INCR_REG) rd_word_o = rd_incr;
        else if (HAS_INCR && reg_num_i == WR_INCR_REG) rd_word_o = wr_incr;
        else if (is_data)                              rd_word_o = rd_data;
    end

    // memory side: ack only answers a live select
    a_ack_in_sel : assert property (@(posedge clk) disable iff (reset_i) ack_i |-> sel_o);

endmodule

// File: xm_ctrl_regs.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// port read words are ORed, so each port must return zero when not addressed
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`include "xm_config.svh"

module xm_ctrl_regs (
    input  logic                   clk,
    input  logic                   reset_i,
    input  logic                   wr_strobe_i,
    input  logic                   rd_strobe_i,
    input  xm_regmap_pkg::xm_reg_t reg_num_i,
    input  logic                   bytesel_i,
    input  xm_types_pkg::byte_t    data_byte_i,
    input  xm_types_pkg::word_t    timer_i,
    input  logic                   vram_busy_i,
    input  logic                   xr_busy_i,
    input  xm_types_pkg::word_t    vram_rd_word_i,
    input  xm_types_pkg::word_t    xr_rd_word_i,
    input  xm_types_pkg::intr_t    intr_status_i,   // pending irqs
    output xm_types_pkg::wrmask_t  wrmask_o,        // VRAM nibble mask
    output xm_types_pkg::intr_t    intr_mask_o,
    output xm_types_pkg::intr_t    intr_clear_o,    // one clk pulse
    output xm_types_pkg::byte_t    bus_data_o
);
    import xm_types_pkg::*;
    import xm_regmap_pkg::*;

    byte_t timer_lo;        // low byte frozen on high byte read
    word_t rd_word;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            wrmask_o     <= `XM_WRMASK_RESET;
            intr_mask_o  <= '0;
            intr_clear_o <= '0;
            timer_lo     <= '0;
        end else begin
            intr_clear_o <= '0;
            if (wr_strobe_i && reg_num_i == SYS_CTRL && bytesel_i) begin
                wrmask_o <= data_byte_i[3:0];
            end
            if (wr_strobe_i && reg_num_i == INT_CTRL) begin
                if (bytesel_i) intr_clear_o <= data_byte_i[6:0];
                else           intr_mask_o  <= data_byte_i[6:0];
            end
            if (rd_strobe_i && !bytesel_i) begin    // any even read, not just TIMER
                timer_lo <= timer_i[7:0];
            end
        end
    end

    always_comb begin
        rd_word = vram_rd_word_i | xr_rd_word_i;
        case (reg_num_i)
            SYS_CTRL: begin
                rd_word               = '0;
                rd_word[SYS_BUSY_BIT] = vram_busy_i || xr_busy_i;
                rd_word[3:0]          = wrmask_o;
            end
            INT_CTRL: rd_word = {1'b0, intr_mask_o, 1'b0, intr_status_i};
            TIMER:    rd_word = {timer_i[15:8], timer_lo};
            default:  ;
        endcase
    end

    assign bus_data_o = bytesel_i ? rd_word[7:0] : rd_word[15:8];

endmodule

// File: xm_reg_interface.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// clk must be > 2x the host bus rate; one access per port in flight
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module xm_reg_interface (
    input  logic                   clk,
    input  logic                   reset_i,
    input  logic                   bus_cs_n_i,
    input  logic                   bus_rd_nwr_i,
    input  xm_regmap_pkg::xm_reg_t bus_reg_num_i,
    input  logic                   bus_bytesel_i,
    input  xm_types_pkg::byte_t    bus_data_i,
    output xm_types_pkg::byte_t    bus_data_o,
    output logic                   vram_sel_o,
    output logic                   vram_wr_o,
    output xm_types_pkg::wrmask_t  vram_wrmask_o,
    output xm_types_pkg::addr_t    vram_addr_o,
    output xm_types_pkg::word_t    vram_data_o,
    input  logic                   vram_ack_i,
    input  xm_types_pkg::word_t    vram_data_i,
    output logic                   xr_sel_o,
    output logic                   xr_wr_o,
    output xm_types_pkg::addr_t    xr_addr_o,
    output xm_types_pkg::word_t    xr_data_o,
    input  logic                   xr_ack_i,
    input  xm_types_pkg::word_t    xr_data_i,
    input  xm_types_pkg::intr_t    intr_status_i,
    output xm_types_pkg::intr_t    intr_mask_o,
    output xm_types_pkg::intr_t    intr_clear_o
);
    import xm_types_pkg::*;
    import xm_regmap_pkg::*;

    logic    wr_strobe;
    logic    rd_strobe;
    xm_reg_t reg_num;
    logic    bytesel;
    byte_t   data_byte;
    word_t   timer;
    logic    vram_busy;
    logic    xr_busy;
    word_t   vram_rd_word;
    word_t   xr_rd_word;

    bus_sync u_bus_sync (
        .clk, .reset_i, .bus_cs_n_i, .bus_rd_nwr_i, .bus_reg_num_i, .bus_bytesel_i,
        .bus_data_i, .wr_strobe_o(wr_strobe), .rd_strobe_o(rd_strobe),
        .reg_num_o(reg_num), .bytesel_o(bytesel), .data_byte_o(data_byte));

    tenth_ms_timer u_timer (.clk, .reset_i, .timer_o(timer));

    xm_mem_port #(.HAS_INCR(1'b1), .RD_ADDR_REG(RD_ADDR), .WR_ADDR_REG(WR_ADDR),
                  .RD_INCR_REG(RD_INCR), .WR_INCR_REG(WR_INCR),
                  .DATA_REG(DATA), .DATA_ALT_REG(DATA_2)) u_vram_port (
        .clk, .reset_i, .wr_strobe_i(wr_strobe), .rd_strobe_i(rd_strobe),
        .reg_num_i(reg_num), .bytesel_i(bytesel), .data_byte_i(data_byte),
        .ack_i(vram_ack_i), .mem_data_i(vram_data_i), .sel_o(vram_sel_o),
        .wr_o(vram_wr_o), .addr_o(vram_addr_o), .data_o(vram_data_o),
        .busy_o(vram_busy), .rd_word_o(vram_rd_word));

    // XR steps by one, incr register numbers are ignored here
    xm_mem_port #(.HAS_INCR(1'b0), .RD_ADDR_REG(RD_XADDR), .WR_ADDR_REG(WR_XADDR),
                  .RD_INCR_REG(RD_INCR), .WR_INCR_REG(WR_INCR),
                  .DATA_REG(XDATA), .DATA_ALT_REG(XDATA)) u_xr_port (
        .clk, .reset_i, .wr_strobe_i(wr_strobe), .rd_strobe_i(rd_strobe),
        .reg_num_i(reg_num), .bytesel_i(bytesel), .data_byte_i(data_byte),
        .ack_i(xr_ack_i), .mem_data_i(xr_data_i), .sel_o(xr_sel_o),
        .wr_o(xr_wr_o), .addr_o(xr_addr_o), .data_o(xr_data_o),
        .busy_o(xr_busy), .rd_word_o(xr_rd_word));

    xm_ctrl_regs u_ctrl_regs (
        .clk, .reset_i, .wr_strobe_i(wr_strobe), .rd_strobe_i(rd_strobe),
        .reg_num_i(reg_num), .bytesel_i(bytesel), .data_byte_i(data_byte),
        .timer_i(timer), .vram_busy_i(vram_busy), .xr_busy_i(xr_busy),
        .vram_rd_word_i(vram_rd_word), .xr_rd_word_i(xr_rd_word), .intr_status_i,
        .wrmask_o(vram_wrmask_o), .intr_mask_o, .intr_clear_o, .bus_data_o);

endmodule

// File: tb_clock_gen.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// 10 ns clock; reset high for the first 16 rising edges
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module tb_clock_gen (
    output logic clk_o,
    output logic reset_o
);
    initial begin
        clk_o   = 1'b0;
        reset_o = 1'b1;
        fork
            forever #5 clk_o = ~clk_o;     // 100 MHz sim clock
            begin
                repeat (16) @(posedge clk_o);
                #1 reset_o = 1'b0;         // released off the edge
            end
        join_none
    end

endmodule

// File: tb_xm_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// directed tests; memory models ack 1..4 cycles after select
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`include "xm_config.svh"

module mem_model (
    input  logic        clk,
    input  logic        sel_i,
    input  logic        wr_i,
    input  logic [15:0] addr_i,
    input  logic [15:0] data_i,
    output logic        ack_o,
    output logic [15:0] data_o
);
    logic [15:0] mem [0:65535];
    int          wait_cnt;

    initial begin
        for (int a = 0; a < 65536; a++) mem[a] = '0;
        ack_o    = 1'b0;
        data_o   = '0;
        wait_cnt = -1;
        forever begin
            @(posedge clk);
            #1;
            if (ack_o) begin                // DUT drops select on this edge
                ack_o    = 1'b0;
                wait_cnt = -1;
            end else if (sel_i) begin
                if (wait_cnt < 0) wait_cnt = $urandom_range(3, 0);
                if (wait_cnt == 0) begin
                    ack_o = 1'b1;
                    if (wr_i) mem[addr_i] = data_i;
                    else      data_o = mem[addr_i];
                end else begin
                    wait_cnt--;
                end
            end
        end
    end
endmodule

module tb_xm_top;
    import xm_types_pkg::*;
    import xm_regmap_pkg::*;

    logic clk, reset_i;
    logic bus_cs_n_i, bus_rd_nwr_i, bus_bytesel_i;
    xm_reg_t bus_reg_num_i;
    byte_t bus_data_i, bus_data_o;
    logic vram_sel_o, vram_wr_o, vram_ack_i, xr_sel_o, xr_wr_o, xr_ack_i;
    wrmask_t vram_wrmask_o;
    addr_t vram_addr_o, xr_addr_o;
    word_t vram_data_o, vram_data_i, xr_data_o, xr_data_i;
    intr_t intr_status_i, intr_mask_o, intr_clear_o;
    int cycles;
    int clear_pulses;       // cycles with a nonzero clear
    intr_t clear_seen;

    tb_clock_gen u_clock_gen (.clk_o(clk), .reset_o(reset_i));

    xm_reg_interface u_xm_reg_interface (.*);

    mem_model u_vram_mem (.clk, .sel_i(vram_sel_o), .wr_i(vram_wr_o), .addr_i(vram_addr_o),
        .data_i(vram_data_o), .ack_o(vram_ack_i), .data_o(vram_data_i));
    mem_model u_xr_mem (.clk, .sel_i(xr_sel_o), .wr_i(xr_wr_o), .addr_i(xr_addr_o),
        .data_i(xr_data_o), .ack_o(xr_ack_i), .data_o(xr_data_i));

    task automatic stop_failed(input string why);
        $display("SOME TESTS FAILED");
        $fatal(1, "%s", why);
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        assert (got === exp) else begin
            $display("mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
            stop_failed("value check failed");
        end
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= 20000) begin
            $display("timeout after %0d cycles", cycles);
            stop_failed("run exceeded cycle limit");
        end
    end

    always @(negedge clk) begin     // away from the edge that updates it
        if (intr_clear_o != '0) begin
            clear_pulses++;
            clear_seen = intr_clear_o;
        end
    end

    // one byte cycle: setup, select low 8 cycles, high 4
    task automatic bus_access(input logic rd, input xm_reg_t r, input logic bsel,
                              input byte_t wdata, output byte_t rdata);
        @(posedge clk);
        #1;
        bus_rd_nwr_i  = rd;
        bus_reg_num_i = r;
        bus_bytesel_i = bsel;
        bus_data_i    = wdata;
        @(posedge clk);
        #1 bus_cs_n_i = 1'b0;
        repeat (4) @(posedge clk);
        #1 rdata = bus_data_o;      // latched reg, before any new fetch lands
        repeat (4) @(posedge clk);
        #1 bus_cs_n_i = 1'b1;
        repeat (4) @(posedge clk);
    endtask

    task automatic host_write(input xm_reg_t r, input logic bsel, input byte_t b);
        byte_t unused;
        bus_access(1'b0, r, bsel, b, unused);
    endtask

    task automatic host_read(input xm_reg_t r, input logic bsel, output byte_t b);
        bus_access(1'b1, r, bsel, 8'h00, b);
    endtask

    task automatic wait_not_busy();
        byte_t hi;
        for (int i = 0; i < 50; i++) begin
            host_read(SYS_CTRL, 1'b0, hi);
            if (!hi[SYS_BUSY_BIT-8]) return;
        end
        stop_failed("busy flag never cleared");
    endtask

    task automatic write_word(input xm_reg_t r, input word_t w);
        wait_not_busy();
        host_write(r, 1'b0, w[15:8]);   // even byte is the high half
        host_write(r, 1'b1, w[7:0]);
    endtask

    task automatic read_word(input xm_reg_t r, output word_t w);
        byte_t hi, lo;
        wait_not_busy();
        host_read(r, 1'b0, hi);
        host_read(r, 1'b1, lo);
        w = {hi, lo};
    endtask

    task automatic reset_readback();
        word_t w;
        read_word(SYS_CTRL, w);
        check_word("SYS_CTRL", w, {12'h000, `XM_WRMASK_RESET});
        for (int i = 1; i < 16; i++) begin
            if (i == int'(TIMER)) continue;   // already counting
            read_word(xm_reg_t'(i), w);
            check_word($sformatf("reg %0d", i), w, 16'h0000);
        end
        check_word("intr_mask_o", {9'h0, intr_mask_o}, 16'h0000);
    endtask

    task automatic vram_write_stride();
        word_t base = 16'h0100;
        word_t incr = 16'h0003;
        write_word(SYS_CTRL, 16'h0005);   // mask nibbles 0 and 2
        write_word(WR_INCR, incr);
        write_word(WR_ADDR, base);
        for (int k = 0; k < 5; k++) write_word(DATA, 16'h1000 + 16'(k) * 16'h0111);
        wait_not_busy();
        for (int k = 0; k < 5; k++) begin
            check_word($sformatf("vram[%h]", base + 16'(k) * incr),
                       u_vram_mem.mem[base + 16'(k) * incr], 16'h1000 + 16'(k) * 16'h0111);
        end
        check_word("vram_wrmask_o", {12'h0, vram_wrmask_o}, 16'h0005);
    endtask

    function automatic word_t fill_word(input addr_t a);
        return {a[7:0], a[15:8]} ^ 16'h5A5A;    // whole address folded in
    endfunction

    task automatic vram_preread_order();
        word_t w;
        addr_t base = 16'h2000;
        for (int k = 0; k < 8; k++) u_vram_mem.mem[base + 16'(k)] = fill_word(base + 16'(k));
        write_word(RD_INCR, 16'h0002);
        write_word(RD_ADDR, base);      // odd byte starts the first fetch
        for (int k = 0; k < 4; k++) begin
            read_word(DATA, w);
            check_word("DATA", w, fill_word(base + 16'(2 * k)));
        end
    endtask

    task automatic xr_round_trip();
        word_t w;
        addr_t base = 16'h0040;
        write_word(WR_XADDR, base);
        for (int k = 0; k < 3; k++) write_word(XDATA, 16'hC000 + 16'(k));
        write_word(RD_XADDR, base);
        for (int k = 0; k < 3; k++) begin
            read_word(XDATA, w);
            check_word("XDATA", w, 16'hC000 + 16'(k));
            check_word("xr mem", u_xr_mem.mem[base + 16'(k)], 16'hC000 + 16'(k));
        end
        read_word(WR_XADDR, w);
        check_word("WR_XADDR", w, base + 16'd3);
    endtask

    task automatic timer_rate();
        byte_t hi, lo;
        word_t t0, t1;
        int c0, c1, expect_ticks, diff;
        c0 = cycles;
        host_read(TIMER, 1'b0, hi);     // latches the low byte
        host_read(TIMER, 1'b1, lo);
        t0 = {hi, lo};
        repeat (500) @(posedge clk);
        c1 = cycles;
        host_read(TIMER, 1'b0, hi);
        host_read(TIMER, 1'b1, lo);
        t1 = {hi, lo};
        expect_ticks = (c1 - c0) * `XM_TIMER_HZ_REDUCED / `XM_TIMER_CLK_REDUCED;
        diff = int'(t1 - t0);
        assert (diff >= expect_ticks - 1 && diff <= expect_ticks + 1) else begin
            $display("mismatch at %0t ns: timer delta got %0d expected %0d +/-1",
                     $time, diff, expect_ticks);
            stop_failed("timer rate check failed");
        end
    endtask

    task automatic interrupt_mask_clear();
        word_t w;
        @(posedge clk);
        #1 intr_status_i = 7'h2A;          // pending sources
        wait_not_busy();
        host_write(INT_CTRL, 1'b0, 8'h55);  // mask
        check_word("intr_mask_o", {9'h0, intr_mask_o}, 16'h0055);
        read_word(INT_CTRL, w);
        check_word("INT_CTRL", w, 16'h552A);    // mask in 14:8, status in 6:0
        clear_pulses = 0;
        host_write(INT_CTRL, 1'b1, 8'h33);  // clear
        check_word("intr_clear_o", {9'h0, clear_seen}, 16'h0033);
        check_word("clear pulse cycles", 16'(clear_pulses), 16'd1);
    endtask

    initial begin
        void'($urandom(66));
        cycles        = 0;
        clear_pulses  = 0;
        clear_seen    = '0;
        bus_cs_n_i    = 1'b1;
        bus_rd_nwr_i  = 1'b1;
        bus_reg_num_i = SYS_CTRL;
        bus_bytesel_i = 1'b0;
        bus_data_i    = '0;
        intr_status_i = '0;
        @(negedge reset_i);
        reset_readback();
        vram_write_stride();
        vram_preread_order();
        xr_round_trip();
        timer_rate();
        interrupt_mask_clear();
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

// File: tb.f
+incdir+.
xm_types_pkg.sv
xm_regmap_pkg.sv
bus_sync.sv
tenth_ms_timer.sv
xm_mem_port.sv
xm_ctrl_regs.sv
xm_reg_interface.sv
tb_clock_gen.sv
tb_xm_top.sv

// File: Makefile
# Verilator build for the register interface testbench
LOG := sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f tb.f --top-module tb_xm_top
	verilator --lint-only -f tb.f --top-module xm_reg_interface

sim:
	verilator --binary --timing --assert -f tb.f --top-module tb_xm_top -o Vtb_xm_top
	-./obj_dir/Vtb_xm_top > $(LOG) 2>&1
	cat $(LOG)
	@if grep -q "SOME TESTS FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "ALL TESTS PASSED" $(LOG) || (echo "no pass message"; exit 1)

clean:
	rm -rf obj_dir $(LOG)
